/* list_ctrl.f */
+incdir+testbench
src/lru_pkg.sv
src/tag_match.sv
src/access_decode.sv
src/recency_lists.sv
src/line_table.sv
src/list_ctrl.sv
testbench/tb_list_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the list controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --top-module tb_list_ctrl -f list_ctrl.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_list_ctrl > sim.log 2>&1
cat sim.log

grep -q "Simulation PASSED" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }

/* testbench/list_model.svh */
`ifndef LIST_MODEL_SVH
`define LIST_MODEL_SVH

// model of the line table and both lists
line_status_t           m_status [depth];
logic [index_width-1:0] m_index  [depth];
// free stack pops from the back, lru queue holds the most recent line in front
int                     m_free [$];
int                     m_lru  [$];

logic [31:0] lcg_state   = 32'h4498ada0;
int          error_count = 0;
int          check_count = 0;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic int rand_below(input int n);
    return int'(lcg_next() >> 16) % n;
endfunction

task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
endtask

function automatic void clear_model();
    m_free = {};
    m_lru  = {};
    for (int i = 0; i < depth; i++) begin
        m_status[i] = ST_INVALID;
        m_index[i]  = '0;
        m_free.push_back(i);
    end
endfunction

// highest numbered live line wins
function automatic int find_line(input logic [index_width-1:0] idx);
    int line;
    line = -1;
    for (int i = 0; i < depth; i++) begin
        if (m_status[i] != ST_INVALID && m_index[i] == idx) begin
            line = i;
        end
    end
    return line;
endfunction

function automatic logic allocate_blocked();
    return m_free.size() == 0 && m_lru.size() > 0 && m_status[m_lru[$]] == ST_FETCH;
endfunction

function automatic int victim_line();
    return (m_free.size() > 0) ? m_free[$] : m_lru[$];
endfunction

function automatic void move_to_head(input int line);
    for (int i = 0; i < m_lru.size(); i++) begin
        if (m_lru[i] == line) begin
            m_lru.delete(i);
            break;
        end
    end
    m_lru.push_front(line);
endfunction

// expected reply for a request against the current model state
function automatic void reference_reply(input logic req, input acc_cmd_t cmd,
        input logic [index_width-1:0] idx, output line_status_t exp_status,
        output logic [tag_width-1:0] exp_tag, output logic [index_width-1:0] exp_index,
        output logic index_known);
    int line;
    exp_status  = ST_INVALID;
    exp_tag     = '0;
    exp_index   = '0;
    index_known = 1'b1;
    if (req && (cmd == CMD_READ || cmd == CMD_WRITE_HIT)) begin
        line = find_line(idx);
        if (line >= 0) begin
            exp_tag    = tag_width'(line);
            exp_status = m_status[line];
            exp_index  = m_index[line];
        end
    end else if (req && cmd == CMD_ALLOC && !allocate_blocked()) begin
        line        = victim_line();
        exp_tag     = tag_width'(line);
        exp_status  = m_status[line];
        exp_index   = m_index[line];
        // a line that was never allocated has no index yet
        index_known = (m_status[line] != ST_INVALID);
    end
endfunction

function automatic void apply_request(input logic req, input acc_cmd_t cmd,
        input logic [index_width-1:0] idx, input logic [tag_width-1:0] tag);
    int line;
    line = -1;
    if (req && (cmd == CMD_READ || cmd == CMD_WRITE_HIT)) begin
        line = find_line(idx);
        if (line >= 0) begin
            move_to_head(line);
            if (cmd == CMD_WRITE_HIT) begin
                m_status[line] = ST_DIRTY;
            end
        end
    end else if (req && cmd == CMD_ALLOC && !allocate_blocked()) begin
        if (m_free.size() > 0) begin
            line = m_free.pop_back();
        end else begin
            line = m_lru.pop_back();
        end
        m_lru.push_front(line);
        m_status[line] = ST_FETCH;
        m_index[line]  = idx;
    end else if (req && cmd == CMD_FILL) begin
        m_status[tag] = ST_VALID;
    end
endfunction

`endif

/* testbench/tb_list_ctrl.sv */
`timescale 1ns/1ns

module tb_list_ctrl;

    import lru_pkg::*;

    localparam int depth         = DEF_LISTS_DEPTH;
    localparam int index_width   = DEF_INDEX_WIDTH;
    localparam int tag_width     = $clog2(depth);
    localparam int reset_timeout = 20;

    logic                   clk;
    logic                   rst_n;
    logic                   acc_req;
    acc_cmd_t               acc_cmd;
    logic [index_width-1:0] acc_index;
    logic [tag_width-1:0]   acc_tag;
    line_status_t           acc_status;
    logic [tag_width-1:0]   return_tag;
    logic [index_width-1:0] return_index;
    logic                   allocate_busy;

    string test_name;
    int    timeout_count = 0;

    `include "list_model.svh"

    list_ctrl #(
        .lists_depth   (depth),
        .index_width   (index_width)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .acc_req       (acc_req),
        .acc_cmd       (acc_cmd),
        .acc_index     (acc_index),
        .acc_tag       (acc_tag),
        .acc_status    (acc_status),
        .return_tag    (return_tag),
        .return_index  (return_index),
        .allocate_busy (allocate_busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_and_finish();
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // one request per cycle, returns once the model has taken it
    task automatic drive_request(input string name, input logic req, input acc_cmd_t cmd,
                                 input logic [index_width-1:0] idx,
                                 input logic [tag_width-1:0] tag);
        @(posedge clk);
        #1;
        test_name = name;
        acc_req   = req;
        acc_cmd   = cmd;
        acc_index = idx;
        acc_tag   = tag;
        @(negedge clk);
        #1;
    endtask

    // replies are combinational, so sample mid cycle
    initial begin : compare_replies
        int                     waited;
        line_status_t           exp_status;
        logic [tag_width-1:0]   exp_tag;
        logic [index_width-1:0] exp_index;
        logic                   index_known;
        waited = 0;
        while (rst_n !== 1'b1 && waited < reset_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("timed out waiting for reset release");
            timeout_count++;
            report_and_finish();
        end else begin
            forever begin
                @(negedge clk);
                reference_reply(acc_req, acc_cmd, acc_index, exp_status, exp_tag,
                                exp_index, index_known);
                compare_value($sformatf("%s allocate_busy", test_name),
                              32'(allocate_blocked()), 32'(allocate_busy));
                compare_value($sformatf("%s acc_status", test_name),
                              32'(exp_status), 32'(acc_status));
                compare_value($sformatf("%s return_tag", test_name),
                              32'(exp_tag), 32'(return_tag));
                if (index_known) begin
                    compare_value($sformatf("%s return_index", test_name),
                                  32'(exp_index), 32'(return_index));
                end
                apply_request(acc_req, acc_cmd, acc_index, acc_tag);
            end
        end
    end

    initial begin : stimulus
        logic [31:0]            r;
        logic [index_width-1:0] idx;
        logic [index_width-1:0] old_index;
        logic [tag_width-1:0]   fetch_tag;
        int                     tag;
        rst_n     = 1'b0;
        acc_req   = 1'b0;
        acc_cmd   = CMD_READ;
        acc_index = '0;
        acc_tag   = '0;
        test_name = "reset";
        clear_model();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // empty table, nothing hits
        for (int i = 0; i < (1 << index_width); i++) begin
            drive_request("reset_read", 1'b1, CMD_READ, index_width'(i), '0);
        end

        for (int i = 0; i < depth; i++) begin
            drive_request("free_alloc", 1'b1, CMD_ALLOC, index_width'(3 * i + 1), '0);
        end
        for (int i = 0; i < depth; i++) begin
            drive_request("fetch_read", 1'b1, CMD_READ, index_width'(3 * i + 1), '0);
        end

        for (int i = 0; i < depth; i++) begin
            tag = find_line(index_width'(3 * i + 1));
            drive_request("fill", 1'b1, CMD_FILL, '0, tag_width'(tag));
            drive_request("valid_read", 1'b1, CMD_READ, index_width'(3 * i + 1), '0);
        end
        drive_request("write_hit", 1'b1, CMD_WRITE_HIT, index_width'(4), '0);
        drive_request("dirty_read", 1'b1, CMD_READ, index_width'(4), '0);
        drive_request("write_hit", 1'b1, CMD_WRITE_HIT, index_width'(7), '0);
        drive_request("dirty_read", 1'b1, CMD_READ, index_width'(7), '0);

        // shuffle recency, then evict
        compare_value("evict_setup", 32'(0), 32'(allocate_busy));
        for (int i = 0; i < 8; i++) begin
            r   = lcg_next();
            tag = rand_below(depth);
            drive_request("lru_touch", 1'b1, r[20] ? CMD_WRITE_HIT : CMD_READ,
                          m_index[tag], '0);
        end
        old_index = m_index[m_lru[$]];
        drive_request("lru_evict", 1'b1, CMD_ALLOC, index_width'(13), '0);
        drive_request("evicted_read", 1'b1, CMD_READ, old_index, '0);

        // push the fetching line down to the tail
        fetch_tag = tag_width'(m_lru[0]);
        for (int i = 0; i < depth; i++) begin
            if (i != fetch_tag) begin
                drive_request("busy_touch", 1'b1, CMD_READ, m_index[i], '0);
            end
        end
        drive_request("busy_alloc", 1'b1, CMD_ALLOC, index_width'(14), '0);
        compare_value("busy_setup", 32'(1), 32'(allocate_busy));
        for (int i = 0; i < (1 << index_width); i++) begin
            if (index_width'(i) != m_index[fetch_tag]) begin
                drive_request("busy_read", 1'b1, CMD_READ, index_width'(i), '0);
            end
        end
        drive_request("busy_fill", 1'b1, CMD_FILL, '0, fetch_tag);
        drive_request("fetched_read", 1'b1, CMD_READ, m_index[fetch_tag], '0);
        compare_value("busy_clear", 32'(0), 32'(allocate_busy));

        // mixed traffic, half the lookups aimed at live lines
        for (int n = 0; n < 400; n++) begin
            r = lcg_next();
            if (r[24]) begin
                idx = m_index[rand_below(depth)];
            end else begin
                idx = index_width'(rand_below(1 << index_width));
            end
            drive_request("random_mix", r[31:29] != 3'b000, r[27:26], idx,
                          tag_width'(rand_below(depth)));
        end
        drive_request("idle", 1'b0, CMD_READ, '0, '0);
        report_and_finish();
    end

endmodule

/* src/list_ctrl.sv */
`timescale 1ns/1ns

module list_ctrl #(
    parameter int lists_depth = lru_pkg::DEF_LISTS_DEPTH,
    parameter int index_width = lru_pkg::DEF_INDEX_WIDTH
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           acc_req,
    input  lru_pkg::acc_cmd_t              acc_cmd,
    input  logic [index_width-1:0]         acc_index,
    input  logic [$clog2(lists_depth)-1:0] acc_tag,
    output lru_pkg::line_status_t          acc_status,
    output logic [$clog2(lists_depth)-1:0] return_tag,
    output logic [index_width-1:0]         return_index,
    output logic                           allocate_busy
);

    import lru_pkg::*;

    localparam int tag_width = $clog2(lists_depth);

    logic                 hit;
    logic [tag_width-1:0] hit_tag;
    logic [tag_width-1:0] victim_tag;
    logic                 alloc;
    logic                 write_hit;
    logic                 fill;
    logic                 touch;
    logic [tag_width-1:0] touch_tag;

    line_status_t           line_status [lists_depth];
    logic [index_width-1:0] line_index  [lists_depth];

    tag_match #(
        .lists_depth (lists_depth),
        .index_width (index_width)
    ) u_tag_match (
        .acc_index   (acc_index),
        .line_status (line_status),
        .line_index  (line_index),
        .hit         (hit),
        .hit_tag     (hit_tag)
    );

    access_decode #(
        .lists_depth   (lists_depth),
        .index_width   (index_width)
    ) u_access_decode (
        .acc_req       (acc_req),
        .acc_cmd       (acc_cmd),
        .hit           (hit),
        .hit_tag       (hit_tag),
        .victim_tag    (victim_tag),
        .allocate_busy (allocate_busy),
        .alloc         (alloc),
        .write_hit     (write_hit),
        .fill          (fill),
        .touch         (touch),
        .touch_tag     (touch_tag),
        .return_tag    (return_tag)
    );

    recency_lists #(
        .lists_depth   (lists_depth),
        .index_width   (index_width)
    ) u_recency_lists (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc         (alloc),
        .touch         (touch),
        .touch_tag     (touch_tag),
        .line_status   (line_status),
        .victim_tag    (victim_tag),
        .allocate_busy (allocate_busy)
    );

    line_table #(
        .lists_depth  (lists_depth),
        .index_width  (index_width)
    ) u_line_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .write_hit    (write_hit),
        .fill         (fill),
        .touch        (touch),
        .acc_index    (acc_index),
        .acc_tag      (acc_tag),
        .return_tag   (return_tag),
        .line_status  (line_status),
        .line_index   (line_index),
        .acc_status   (acc_status),
        .return_index (return_index)
    );

endmodule

/* src/line_table.sv */
`timescale 1ns/1ns

module line_table #(
    parameter int lists_depth = lru_pkg::DEF_LISTS_DEPTH,
    parameter int index_width = lru_pkg::DEF_INDEX_WIDTH
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           alloc,
    input  logic                           write_hit,
    input  logic                           fill,
    input  logic                           touch,
    input  logic [index_width-1:0]         acc_index,
    input  logic [$clog2(lists_depth)-1:0] acc_tag,
    input  logic [$clog2(lists_depth)-1:0] return_tag,
    output lru_pkg::line_status_t          line_status [lists_depth],
    output logic [index_width-1:0]         line_index  [lists_depth],
    output lru_pkg::line_status_t          acc_status,
    output logic [index_width-1:0]         return_index
);

    import lru_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < lists_depth; i++) begin
                line_status[i] <= ST_INVALID;
            end
        end else if (alloc) begin
            line_status[return_tag] <= ST_FETCH;
        end else if (write_hit) begin
            line_status[return_tag] <= ST_DIRTY;
        end else if (fill) begin
            // fill addresses the line directly by tag
            line_status[acc_tag] <= ST_VALID;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            line_index[return_tag] <= acc_index;
        end
    end

    // old contents of the returned line, before this cycle's update
    always_comb begin
        acc_status   = ST_INVALID;
        return_index = '0;
        if (alloc || touch) begin
            acc_status   = line_status[return_tag];
            return_index = line_index[return_tag];
        end
    end

endmodule

/* src/recency_lists.sv */
`timescale 1ns/1ns

module recency_lists #(
    parameter int lists_depth = lru_pkg::DEF_LISTS_DEPTH,
    parameter int index_width = lru_pkg::DEF_INDEX_WIDTH
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           alloc,
    input  logic                           touch,
    input  logic [$clog2(lists_depth)-1:0] touch_tag,
    input  lru_pkg::line_status_t          line_status [lists_depth],
    output logic [$clog2(lists_depth)-1:0] victim_tag,
    output logic                           allocate_busy
);

    import lru_pkg::*;

    localparam int tag_width = $clog2(lists_depth);

    logic [tag_width-1:0] prev_tag [lists_depth];
    logic [tag_width-1:0] next_tag [lists_depth];

    // free list only ever pops from its tail
    logic [tag_width-1:0] free_tail;
    logic [tag_width:0]   free_len;

    logic [tag_width-1:0] lru_head;
    logic [tag_width-1:0] lru_tail;
    logic [tag_width:0]   lru_len;

    logic                 free_empty;
    logic                 lru_empty;
    logic                 from_free;
    logic                 relink;
    logic [tag_width-1:0] move_tag;
    logic [tag_width-1:0] move_prev;
    logic [tag_width-1:0] move_next;

    assign free_empty = (free_len == '0);
    assign lru_empty  = (lru_len == '0);

    assign victim_tag    = free_empty ? lru_tail : free_tail;
    assign allocate_busy = free_empty && line_status[lru_tail] == ST_FETCH;

    // eviction is just a move of the lru tail to the head
    assign from_free = alloc && !free_empty;
    assign relink    = touch || (alloc && free_empty);
    assign move_tag  = touch ? touch_tag : victim_tag;
    assign move_prev = prev_tag[move_tag];
    assign move_next = next_tag[move_tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_tail <= tag_width'(lists_depth - 1);
            free_len  <= (tag_width + 1)'(lists_depth);
            lru_head  <= '0;
            lru_tail  <= '0;
            lru_len   <= '0;
        end else if (from_free) begin
            free_tail <= prev_tag[free_tail];
            free_len  <= free_len - 1'b1;
            lru_head  <= free_tail;
            lru_len   <= lru_len + 1'b1;
            if (lru_empty) begin
                lru_tail <= free_tail;
            end
        end else if (relink && move_tag != lru_head) begin
            lru_head <= move_tag;
            if (move_tag == lru_tail) begin
                lru_tail <= move_prev;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // all lines chained in order on the free list
            for (int i = 0; i < lists_depth; i++) begin
                if (i == 0) begin
                    prev_tag[i] <= tag_width'(lists_depth - 1);
                end else begin
                    prev_tag[i] <= tag_width'(i - 1);
                end
                if (i == lists_depth - 1) begin
                    next_tag[i] <= '0;
                end else begin
                    next_tag[i] <= tag_width'(i + 1);
                end
            end
        end else if (from_free) begin
            if (!lru_empty) begin
                next_tag[free_tail] <= lru_head;
                prev_tag[lru_head]  <= free_tail;
            end
        end else if (relink && move_tag != lru_head) begin
            // unlink
            next_tag[move_prev] <= move_next;
            if (move_tag != lru_tail) begin
                prev_tag[move_next] <= move_prev;
            end
            // push at head
            next_tag[move_tag] <= lru_head;
            prev_tag[lru_head] <= move_tag;
        end
    end

endmodule

/* src/access_decode.sv */
`timescale 1ns/1ns

module access_decode #(
    parameter int lists_depth = lru_pkg::DEF_LISTS_DEPTH,
    parameter int index_width = lru_pkg::DEF_INDEX_WIDTH
) (
    input  logic                           acc_req,
    input  lru_pkg::acc_cmd_t              acc_cmd,
    input  logic                           hit,
    input  logic [$clog2(lists_depth)-1:0] hit_tag,
    input  logic [$clog2(lists_depth)-1:0] victim_tag,
    input  logic                           allocate_busy,
    output logic                           alloc,
    output logic                           write_hit,
    output logic                           fill,
    output logic                           touch,
    output logic [$clog2(lists_depth)-1:0] touch_tag,
    output logic [$clog2(lists_depth)-1:0] return_tag
);

    import lru_pkg::*;

    logic is_lookup;

    assign is_lookup = acc_req && (acc_cmd == CMD_WRITE_HIT || acc_cmd == CMD_READ);

    assign touch     = is_lookup && hit;
    assign write_hit = touch && acc_cmd == CMD_WRITE_HIT;
    assign fill      = acc_req && acc_cmd == CMD_FILL;

    // an allocate on a line still being fetched is dropped
    assign alloc = acc_req && acc_cmd == CMD_ALLOC && !allocate_busy;

    assign touch_tag = hit_tag;

    always_comb begin
        return_tag = '0;
        if (touch) begin
            return_tag = hit_tag;
        end else if (alloc) begin
            return_tag = victim_tag;
        end
    end

endmodule

/* src/tag_match.sv */
`timescale 1ns/1ns

module tag_match #(
    parameter int lists_depth = lru_pkg::DEF_LISTS_DEPTH,
    parameter int index_width = lru_pkg::DEF_INDEX_WIDTH
) (
    input  logic [index_width-1:0]         acc_index,
    input  lru_pkg::line_status_t          line_status [lists_depth],
    input  logic [index_width-1:0]         line_index  [lists_depth],
    output logic                           hit,
    output logic [$clog2(lists_depth)-1:0] hit_tag
);

    import lru_pkg::*;

    localparam int tag_width = $clog2(lists_depth);

    // search every live line, later lines override earlier ones
    always_comb begin
        hit     = 1'b0;
        hit_tag = '0;
        for (int i = 0; i < lists_depth; i++) begin
            if (line_status[i] != ST_INVALID && line_index[i] == acc_index) begin
                hit     = 1'b1;
                hit_tag = tag_width'(i);
            end
        end
    end

endmodule

/* src/lru_pkg.sv */
package lru_pkg;

    // line status codes
    typedef logic [2:0] line_status_t;

    localparam line_status_t ST_INVALID = 3'b000;
    // fetch in progress, line not yet usable
    localparam line_status_t ST_FETCH   = 3'b100;
    localparam line_status_t ST_VALID   = 3'b001;
    localparam line_status_t ST_DIRTY   = 3'b010;

    // access port commands
    typedef logic [1:0] acc_cmd_t;

    localparam acc_cmd_t CMD_WRITE_HIT = 2'b00;
    localparam acc_cmd_t CMD_READ      = 2'b01;
    localparam acc_cmd_t CMD_ALLOC     = 2'b10;
    localparam acc_cmd_t CMD_FILL      = 2'b11;

    // default sizes for the top level
    localparam int DEF_LISTS_DEPTH = 4;
    localparam int DEF_INDEX_WIDTH = 4;

endpackage
